// ==== congestion_pkg.sv ====
`default_nettype none

package congestion_pkg;

    localparam int NUM_PORTS = 5; // mesh router, local plus four neighbours
    localparam int CONGW     = 2; // congestion level width
    localparam int PPSW      = 4; // one pre-select bit per quadrant

    // port index, also the slice position in the per-VC vectors
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_dir_e;

    // bit position in the pre-select word
    typedef enum logic [1:0] {
        Q0 = 2'd0, // x-minus, y-minus
        Q1 = 2'd1, // x-minus, y-plus
        Q2 = 2'd2, // x-plus, y-minus
        Q3 = 2'd3  // x-plus, y-plus
    } quadrant_e;

    typedef logic [CONGW-1:0] cong_level_t; // 0 least, 3 most congested

    // one level per port, local in the low bits
    typedef struct packed {
        cong_level_t south;
        cong_level_t west;
        cong_level_t north;
        cong_level_t east;
        cong_level_t lcl;
    } cong_vec_t;

    // 0 prefers x, 1 prefers y
    typedef struct packed {
        logic q3;
        logic q2;
        logic q1;
        logic q0;
    } port_presel_t;

endpackage

`default_nettype wire

// ==== ivc_congestion_meter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ivc_congestion_meter
    import congestion_pkg::*;
#(
    parameter int V = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [NUM_PORTS*V-1:0] ivc_request,
    input  wire logic [NUM_PORTS*V-1:0] ivc_granted,
    output cong_vec_t                   congestion_out
);

    localparam int PV   = NUM_PORTS * V;
    localparam int CNTW = $clog2(PV + 1);

    // level thresholds, integer division of the VC count
    localparam int TH_LOW  = PV / 10;
    localparam int TH_MID  = PV / 5;
    localparam int TH_HIGH = PV / 2;

    logic [PV-1:0]   pend_q;   // requesting VCs that lost arbitration
    logic [CNTW-1:0] pend_num;
    cong_level_t     level;

    // first stage, capture not-granted requests
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q <= '0;
        end else begin
            pend_q <= ivc_request & ~ivc_granted;
        end
    end

    // population count over all input VCs
    always_comb begin
        pend_num = '0;
        for (int b = 0; b < PV; b++) begin
            pend_num = pend_num + CNTW'(pend_q[b]);
        end
    end

    always_comb begin
        if (int'(pend_num) <= TH_LOW) begin
            level = cong_level_t'(0); // up to 10 percent
        end else if (int'(pend_num) <= TH_MID) begin
            level = cong_level_t'(1); // up to 20 percent
        end else if (int'(pend_num) <= TH_HIGH) begin
            level = cong_level_t'(2); // up to half
        end else begin
            level = cong_level_t'(3);
        end
    end

    // second stage, same level reported to every neighbour
    always_ff @(posedge clk) begin
        if (rst) begin
            congestion_out <= '0;
        end else begin
            congestion_out <= cong_vec_t'({NUM_PORTS{level}});
        end
    end

endmodule

`default_nettype wire

// ==== port_presel_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_presel_gen
    import congestion_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire cong_vec_t congestion_in,
    output port_presel_t   port_pre_sel
);

    /*
     * quadrants seen from this router
     *
     *          north
     *      Q1    |    Q3
     *  west -----+----- east
     *      Q0    |    Q2
     *          south
     *
     * a bit goes high when the x neighbour reports more congestion
     * than the y neighbour, ties keep the x direction
     */

    logic [PPSW-1:0] cong_cmp;

    always_comb begin
        cong_cmp       = '0;
        cong_cmp[Q3]   = congestion_in.east > congestion_in.north;
        cong_cmp[Q1]   = congestion_in.west > congestion_in.north;
        cong_cmp[Q2]   = congestion_in.east > congestion_in.south;
        cong_cmp[Q0]   = congestion_in.west > congestion_in.south;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            port_pre_sel <= '0; // x preferred everywhere
        end else begin
            port_pre_sel <= port_presel_t'(cong_cmp);
        end
    end

endmodule

`default_nettype wire

// ==== deadlock_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

module deadlock_detector
    import congestion_pkg::*;
#(
    parameter int V       = 4,
    parameter int MAX_CLK = 16
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [NUM_PORTS*V-1:0] ivc_request,
    input  wire logic [NUM_PORTS*V-1:0] ivc_granted,
    output logic                        deadlock_detect
);

    localparam int PV   = NUM_PORTS * V;
    localparam int CNTW = (MAX_CLK <= 2) ? 1 : $clog2(MAX_CLK);

    localparam logic [CNTW-1:0] LIMIT = CNTW'(MAX_CLK - 1);

    logic [PV-1:0]   gnt_q;
    logic [V-1:0]    vc_clr;   // same VC index granted on any port
    logic [V-1:0]    vc_req;   // same VC index requesting on any port
    logic [V-1:0]    at_limit;
    logic [CNTW-1:0] wait_cnt [V];

    always_ff @(posedge clk) begin
        if (rst) begin
            gnt_q <= '0;
        end else begin
            gnt_q <= ivc_granted;
        end
    end

    // fold the five port slices onto the VC index
    always_comb begin
        vc_clr = '0;
        vc_req = '0;
        for (int i = 0; i < V; i++) begin
            for (int p = LOCAL; p <= SOUTH; p++) begin
                vc_clr[i] = vc_clr[i] | gnt_q[p*V+i];
                vc_req[i] = vc_req[i] | ivc_request[p*V+i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < V; i++) begin
                wait_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < V; i++) begin
                if (vc_clr[i]) begin
                    wait_cnt[i] <= '0;
                end else if (vc_req[i]) begin
                    if (wait_cnt[i] == LIMIT) begin
                        wait_cnt[i] <= '0; // wrap, flag repeats while stuck
                    end else begin
                        wait_cnt[i] <= wait_cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < V; i++) begin
            at_limit[i] = (wait_cnt[i] == LIMIT);
        end
    end

    assign deadlock_detect = |at_limit;

endmodule

`default_nettype wire

// ==== congestion_analyzer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module congestion_analyzer_top
    import congestion_pkg::*;
#(
    parameter int V       = 4,  // VCs per port
    parameter int MAX_CLK = 16  // deadlock wait limit in cycles
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [NUM_PORTS*V-1:0] ivc_request,
    input  wire logic [NUM_PORTS*V-1:0] ivc_granted,
    input  wire cong_vec_t              congestion_in,
    output cong_vec_t                   congestion_out,
    output port_presel_t                port_pre_sel,
    output logic                        deadlock_detect
);

    // own congestion, broadcast to the neighbours
    ivc_congestion_meter #(
        .V (V)
    ) ivc_congestion_meter_i (
        .clk            (clk),
        .rst            (rst),
        .ivc_request    (ivc_request),
        .ivc_granted    (ivc_granted),
        .congestion_out (congestion_out)
    );

    // quadrant choice from neighbour reports
    port_presel_gen port_presel_gen_i (
        .clk           (clk),
        .rst           (rst),
        .congestion_in (congestion_in),
        .port_pre_sel  (port_pre_sel)
    );

    deadlock_detector #(
        .V       (V),
        .MAX_CLK (MAX_CLK)
    ) deadlock_detector_i (
        .clk             (clk),
        .rst             (rst),
        .ivc_request     (ivc_request),
        .ivc_granted     (ivc_granted),
        .deadlock_detect (deadlock_detect)
    );

endmodule

`default_nettype wire

// ==== congestion_analyzer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module congestion_analyzer_tb
    import congestion_pkg::*;
();

    localparam int V          = 4;
    localparam int MAX_CLK    = 16;
    localparam int PV         = NUM_PORTS * V;
    localparam int DL_TIMEOUT = 40;
    localparam int STUCK_BIT  = int'(NORTH) * V + 2; // vc 2 on the north port

    typedef struct packed {
        logic [PV-1:0] req;
        logic [PV-1:0] gnt;
        cong_vec_t     cin;
        cong_level_t   lvl;
        port_presel_t  ps;
    } row_t;

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    logic [PV-1:0] ivc_request = '0;
    logic [PV-1:0] ivc_granted = '0;
    cong_vec_t     congestion_in = '0;
    cong_vec_t     congestion_out;
    port_presel_t  port_pre_sel;
    logic          deadlock_detect;

    row_t  rows [$];
    string row_names [$];

    always #4 clk = ~clk;

    congestion_analyzer_top #(
        .V       (V),
        .MAX_CLK (MAX_CLK)
    ) congestion_analyzer_top_i (
        .clk             (clk),
        .rst             (rst),
        .ivc_request     (ivc_request),
        .ivc_granted     (ivc_granted),
        .congestion_in   (congestion_in),
        .congestion_out  (congestion_out),
        .port_pre_sel    (port_pre_sel),
        .deadlock_detect (deadlock_detect)
    );

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic cong_vec_t make_cong(input int s, input int w, input int n,
                                            input int e, input int l);
        cong_vec_t c;
        c.south = cong_level_t'(s);
        c.west  = cong_level_t'(w);
        c.north = cong_level_t'(n);
        c.east  = cong_level_t'(e);
        c.lcl   = cong_level_t'(l);
        return c;
    endfunction

    // pending = requested and not granted, thresholds at 10, 20 and 50 percent
    function automatic cong_level_t expected_level(input logic [PV-1:0] req,
                                                   input logic [PV-1:0] gnt);
        int n;
        n = $countones(req & ~gnt);
        if (n <= PV / 10) return 2'd0;
        if (n <= PV / 5) return 2'd1;
        if (n <= PV / 2) return 2'd2;
        return 2'd3;
    endfunction

    function automatic port_presel_t expected_presel(input cong_vec_t c);
        port_presel_t p;
        p.q3 = (c.east > c.north); // x only wins a tie
        p.q2 = (c.east > c.south);
        p.q1 = (c.west > c.north);
        p.q0 = (c.west > c.south);
        return p;
    endfunction

    function automatic cong_vec_t broadcast(input cong_level_t lvl);
        return make_cong(lvl, lvl, lvl, lvl, lvl);
    endfunction

    task automatic add_row(input string name, input logic [PV-1:0] req,
                           input logic [PV-1:0] gnt, input cong_vec_t cin,
                           input cong_level_t lvl, input port_presel_t ps);
        row_t r;
        r.req = req;
        r.gnt = gnt;
        r.cin = cin;
        r.lvl = lvl;
        r.ps  = ps;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    // called at a falling edge, returns at a falling edge
    task automatic apply_row(input string name, input row_t r);
        ivc_request   = r.req;
        ivc_granted   = r.gnt;
        congestion_in = r.cin;
        repeat (3) @(negedge clk); // meter latency is two edges
        check({name, "_level"}, broadcast(r.lvl), congestion_out);
        check({name, "_presel"}, r.ps, port_pre_sel);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst           = 1'b1;
        ivc_request   = '1; // busy inputs, only the reset keeps outputs at 0
        ivc_granted   = '0;
        congestion_in = make_cong(0, 3, 0, 3, 3);
        repeat (16) @(negedge clk);
        rst           = 1'b0;
        ivc_request   = '0;
        congestion_in = '0;
    endtask

    initial begin
        row_t          r;
        logic [PV-1:0] req;
        logic [PV-1:0] gnt;
        cong_vec_t     cin;
        int            cycles;

        void'($urandom(32'hc2fee550));

        add_row("req_0", 20'h00000, '0, '0, 2'd0, 4'b0000);
        add_row("req_2", 20'h00003, '0, '0, 2'd0, 4'b0000);
        add_row("req_3", 20'h00007, '0, '0, 2'd1, 4'b0000);
        add_row("req_4", 20'h0000f, '0, '0, 2'd1, 4'b0000);
        add_row("req_5", 20'h0001f, '0, '0, 2'd2, 4'b0000);
        add_row("req_10", 20'h003ff, '0, '0, 2'd2, 4'b0000);
        add_row("req_11", 20'h007ff, '0, '0, 2'd3, 4'b0000);
        add_row("req_20", 20'hfffff, '0, '0, 2'd3, 4'b0000);
        add_row("req_12_gnt_8", 20'h00fff, 20'h000ff, '0, 2'd1, 4'b0000);
        add_row("ps_east_hot", '0, '0, make_cong(2, 0, 1, 3, 0), 2'd0, 4'b1100);
        add_row("ps_all_tie", '0, '0, make_cong(2, 2, 2, 2, 2), 2'd0, 4'b0000);
        add_row("ps_west_hot", '0, '0, make_cong(0, 3, 1, 1, 0), 2'd0, 4'b0111);
        add_row("ps_south_low", '0, '0, make_cong(1, 2, 2, 2, 0), 2'd0, 4'b0101);
        add_row("ps_local_only", '0, '0, make_cong(0, 0, 0, 0, 3), 2'd0, 4'b0000);

        apply_reset();
        check("reset_congestion_out", 0, congestion_out);
        check("reset_port_pre_sel", 0, port_pre_sel);
        check("reset_deadlock_detect", 0, deadlock_detect);

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(row_names[i], rows[i]);
        end

        for (int k = 0; k < 50; k++) begin
            req   = PV'($urandom());
            gnt   = PV'($urandom() & $urandom()); // sparser grants
            cin   = cong_vec_t'($urandom());
            r.req = req;
            r.gnt = gnt;
            r.cin = cin;
            r.lvl = expected_level(req, gnt);
            r.ps  = expected_presel(cin);
            apply_row($sformatf("random_%0d", k), r);
        end

        // stuck request, never granted
        apply_reset();
        ivc_request[STUCK_BIT] = 1'b1;
        cycles = 0;
        while (deadlock_detect !== 1'b1 && cycles < DL_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (deadlock_detect !== 1'b1) begin
            $display("deadlock_detect did not rise within %0d cycles of a stuck request",
                     DL_TIMEOUT);
            stop_with_failure();
        end
        check("deadlock_rise_cycle", MAX_CLK - 1, cycles);
        @(negedge clk);
        check("deadlock_fall", 0, deadlock_detect);

        // same request, granted every 8 cycles
        apply_reset();
        ivc_request[STUCK_BIT] = 1'b1;
        for (int k = 0; k < 64; k++) begin
            @(negedge clk);
            check($sformatf("deadlock_quiet_%0d", k), 0, deadlock_detect);
            ivc_granted            = '0;
            ivc_granted[STUCK_BIT] = ((k % 8) == 7); // one-cycle grant strobe
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
congestion_pkg.sv
ivc_congestion_meter.sv
port_presel_gen.sv
deadlock_detector.sv
congestion_analyzer_top.sv
congestion_analyzer_tb.sv

// ==== Bender.yml ====
package:
  name: congestion_analyzer

sources:
  - congestion_pkg.sv
  - ivc_congestion_meter.sv
  - port_presel_gen.sv
  - deadlock_detector.sv
  - congestion_analyzer_top.sv
  - target: simulation
    files:
      - congestion_analyzer_tb.sv
